// ==== vlog.f ====
design/cpuPkg.sv
design/mem2Reg.sv
design/mem2Stage.sv
design/dataRam.sv
design/loadAlign.sv
design/wbStage.sv
design/memBackEnd.sv
bench/memBackEndTb.sv

// ==== bench/memBackEndTb.sv ====
`timescale 1ns/1ps

module memBackEndTb;

    logic                            clk = 1'b0;
    logic                            rstN;
    cpuPkg::memBundleT               memIn;
    logic                            mem2Wr;
    logic                            mem2Flush;
    logic [cpuPkg::dataWidth-1:0]    mem2Result;
    logic [cpuPkg::regAddrWidth-1:0] mem2Dst;
    cpuPkg::regsWrT                  mem2RegsWr;
    cpuPkg::wbWriteT                 wbWrite;
    cpuPkg::hiLoWriteT               hiLoWrite;

    // stimulus table with expected values filled in by the model
    string             names [40];
    cpuPkg::memBundleT stim [40];
    logic              wrs [40];
    logic              flushes [40];
    logic [31:0]       expResult [40];
    logic [4:0]        expDst [40];
    cpuPkg::regsWrT    expRegsWr [40];
    cpuPkg::wbWriteT   expWb [40];
    cpuPkg::hiLoWriteT expHiLo [40];
    int                numTests = 0;

    logic [31:0] refMem [256];   // mirror of the data RAM
    logic [31:0] lcgState = 32'd33;
    int          cycles = 0;
    int          errors = 0;
    int          passCount = 0;
    int          failCount = 0;

    always #5 clk = ~clk;

    memBackEnd u_memBackEnd (
        .clk        (clk),
        .rstN       (rstN),
        .memIn      (memIn),
        .mem2Wr     (mem2Wr),
        .mem2Flush  (mem2Flush),
        .mem2Result (mem2Result),
        .mem2Dst    (mem2Dst),
        .mem2RegsWr (mem2RegsWr),
        .wbWrite    (wbWrite),
        .hiLoWrite  (hiLoWrite)
    );

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // rw bits are {rfWr, hiWr, loWr}
    function automatic cpuPkg::memBundleT regOp(input cpuPkg::wbSelT sel,
                                               input logic [4:0] dst, input logic [2:0] rw);
        cpuPkg::memBundleT op;
        op        = '0;
        op.pc     = lcgNext() & ~32'd3;
        op.aluOut = lcgNext();
        op.outB   = lcgNext();
        op.dst    = dst;
        op.wbSel  = sel;
        op.regsWr = rw;
        return op;
    endfunction

    function automatic cpuPkg::memBundleT storeOp(input logic [31:0] addr,
                                                 input logic [31:0] data,
                                                 input cpuPkg::storeTypeT st);
        cpuPkg::memBundleT op;
        op           = regOp(cpuPkg::wbAluOut, 5'd0, 3'b000);
        op.aluOut    = addr;
        op.outB      = data;
        op.storeType = st;
        return op;
    endfunction

    function automatic cpuPkg::memBundleT loadOp(input logic [31:0] addr,
                                                input logic [4:0] dst,
                                                input cpuPkg::loadTypeT lt);
        cpuPkg::memBundleT op;
        op          = regOp(cpuPkg::wbDmOut, dst, 3'b100);
        op.aluOut   = addr;
        op.loadType = lt;
        return op;
    endfunction

    // shift the lane down and let signed assignment do the extension
    function automatic logic [31:0] extend(input logic [31:0] word, input logic [1:0] off,
                                           input cpuPkg::loadTypeT lt);
        logic [31:0]        sh;
        logic signed [7:0]  b8;
        logic signed [15:0] h16;
        logic signed [31:0] ext;
        sh  = word >> (8 * off);
        b8  = sh[7:0];
        sh  = word >> (16 * off[1]);
        h16 = sh[15:0];
        case (lt)
            cpuPkg::ldByte:  ext = b8;
            cpuPkg::ldByteU: ext = {24'd0, b8};
            cpuPkg::ldHalf:  ext = h16;
            cpuPkg::ldHalfU: ext = {16'd0, h16};
            default:         ext = word;
        endcase
        return ext;
    endfunction

    function automatic logic [31:0] pickData(input cpuPkg::mem2BundleT q,
                                             input logic [31:0] rd, input logic isWb);
        case (q.wbSel)
            cpuPkg::wbPcPlus8: return q.pc + 32'd8;
            cpuPkg::wbAluOut:  return q.aluOut;
            cpuPkg::wbOutB:    return q.outB;
            default:           return isWb ? extend(rd, q.aluOut[1:0], q.loadType) : q.outB;
        endcase
    endfunction

    task automatic addTest(input string name, input cpuPkg::memBundleT op,
                           input logic wr, input logic fl);
        names[numTests]   = name;
        stim[numTests]    = op;
        wrs[numTests]     = wr;
        flushes[numTests] = fl;
        numTests++;
    endtask

    task automatic buildTable();
        addTest("resetIdle", '0, 1'b0, 1'b0);
        addTest("aluFwd", regOp(cpuPkg::wbAluOut, 5'd3, 3'b100), 1'b1, 1'b0);
        addTest("pcPlus8", regOp(cpuPkg::wbPcPlus8, 5'd31, 3'b100), 1'b1, 1'b0);
        addTest("outBFwd", regOp(cpuPkg::wbOutB, 5'd7, 3'b100), 1'b1, 1'b0);
        addTest("swWord", storeOp(32'h100, lcgNext(), cpuPkg::stWord), 1'b1, 1'b0);
        addTest("lwWord", loadOp(32'h100, 5'd8, cpuPkg::ldWord), 1'b1, 1'b0);
        addTest("swInit", storeOp(32'h104, lcgNext(), cpuPkg::stWord), 1'b1, 1'b0);
        for (int k = 0; k < 4; k++) begin
            addTest($sformatf("sb%0d", k), storeOp(32'h104 + k,
                    lcgNext() | (k[0] ? 32'h80 : 32'h0), cpuPkg::stByte), 1'b1, 1'b0);
        end
        for (int k = 0; k < 4; k++) begin
            addTest($sformatf("lb%0d", k), loadOp(32'h104 + k, 5'd9, cpuPkg::ldByte), 1'b1, 1'b0);
        end
        addTest("lbu1", loadOp(32'h105, 5'd10, cpuPkg::ldByteU), 1'b1, 1'b0);
        addTest("lbu3", loadOp(32'h107, 5'd10, cpuPkg::ldByteU), 1'b1, 1'b0);
        addTest("sh2", storeOp(32'h106, lcgNext() | 32'h8000, cpuPkg::stHalf), 1'b1, 1'b0);
        addTest("sh0", storeOp(32'h104, lcgNext() & ~32'h8000, cpuPkg::stHalf), 1'b1, 1'b0);
        addTest("lh2", loadOp(32'h106, 5'd11, cpuPkg::ldHalf), 1'b1, 1'b0);
        addTest("lhu2", loadOp(32'h106, 5'd11, cpuPkg::ldHalfU), 1'b1, 1'b0);
        addTest("lh0", loadOp(32'h104, 5'd11, cpuPkg::ldHalf), 1'b1, 1'b0);
        addTest("flushSw", storeOp(32'h100, lcgNext(), cpuPkg::stWord), 1'b1, 1'b1);
        addTest("lwAfterFlush", loadOp(32'h100, 5'd8, cpuPkg::ldWord), 1'b1, 1'b0);
        addTest("flushAlu", regOp(cpuPkg::wbAluOut, 5'd4, 3'b100), 1'b1, 1'b1);
        // load held in MEM2 so its read data must hold too
        addTest("stallHead", loadOp(32'h104, 5'd12, cpuPkg::ldWord), 1'b1, 1'b0);
        addTest("stallA", regOp(cpuPkg::wbAluOut, 5'd13, 3'b100), 1'b0, 1'b0);
        addTest("stallB", regOp(cpuPkg::wbAluOut, 5'd13, 3'b100), 1'b0, 1'b0);
        addTest("mthi", regOp(cpuPkg::wbOutB, 5'd0, 3'b010), 1'b1, 1'b0);
        addTest("mtlo", regOp(cpuPkg::wbOutB, 5'd0, 3'b001), 1'b1, 1'b0);
        addTest("drain0", '0, 1'b1, 1'b0);
        addTest("drain1", '0, 1'b1, 1'b0);
    endtask

    // walks the table once with one clock edge per entry
    task automatic runModel();
        cpuPkg::mem2BundleT m2Q;
        cpuPkg::mem2BundleT wbQ;
        cpuPkg::memBundleT  op;
        logic [31:0]        rdM;
        logic [31:0]        rdQ;
        logic [31:0]        rdNext;
        logic [31:0]        w;
        logic [7:0]         idx;
        m2Q = '0;
        rdM = '0;
        for (int i = 0; i < numTests; i++) begin
            op     = stim[i];
            idx    = op.aluOut[9:2];
            rdNext = refMem[idx];              // read sees the old word
            wbQ    = m2Q;
            rdQ    = rdM;
            if (!wrs[i]) wbQ.regsWr = '0;      // held entry reaches WB as a bubble
            if (wrs[i]) begin
                if (!flushes[i] && op.storeType != cpuPkg::stNone) begin
                    w = refMem[idx];
                    case (op.storeType)
                        cpuPkg::stWord: w = op.outB;
                        cpuPkg::stHalf: w[16*op.aluOut[1] +: 16] = op.outB[15:0];
                        default:        w[8*op.aluOut[1:0] +: 8] = op.outB[7:0];
                    endcase
                    refMem[idx] = w;
                end
                m2Q = flushes[i] ? '0 : op[$bits(cpuPkg::memBundleT)-1:2];   // drop storeType
                rdM = rdNext;
            end
            expResult[i] = pickData(m2Q, 32'd0, 1'b0);
            expDst[i]    = m2Q.dst;
            expRegsWr[i] = m2Q.regsWr;
            expWb[i]     = {wbQ.regsWr.rfWr, wbQ.dst, pickData(wbQ, rdQ, 1'b1)};
            expHiLo[i]   = {wbQ.regsWr.hiWr, wbQ.regsWr.loWr, wbQ.outB};
        end
    endtask

    task automatic checkWord(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s %s expected %h actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic checkRegsWr(input string name, input cpuPkg::regsWrT exp,
                               input cpuPkg::regsWrT act);
        if (act !== exp) begin
            $display("MISMATCH %s mem2RegsWr expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic checkWbWrite(input string name, input cpuPkg::wbWriteT exp,
                                input cpuPkg::wbWriteT act);
        if (act !== exp) begin
            $display("MISMATCH %s wbWrite expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic checkHiLo(input string name, input cpuPkg::hiLoWriteT exp,
                             input cpuPkg::hiLoWriteT act);
        if (act !== exp) begin
            $display("MISMATCH %s hiLoWrite expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic finishTest(input int i);
        errors = 0;
        checkWord(names[i], "mem2Result", expResult[i], mem2Result);
        checkWord(names[i], "mem2Dst", {27'd0, expDst[i]}, {27'd0, mem2Dst});
        checkRegsWr(names[i], expRegsWr[i], mem2RegsWr);
        checkWbWrite(names[i], expWb[i], wbWrite);
        checkHiLo(names[i], expHiLo[i], hiLoWrite);
        if (errors == 0) passCount++;
        else failCount++;
        $display("test %s %s", names[i], (errors == 0) ? "ok" : "failed");
    endtask

    // guard against a stuck run
    always @(posedge clk) begin
        cycles++;
        if (cycles > numTests * 4 + 20) begin
            $display("timeout, run went past %0d cycles", numTests * 4 + 20);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        rstN      = 1'b0;
        memIn     = '0;
        mem2Wr    = 1'b0;
        mem2Flush = 1'b0;
        buildTable();
        runModel();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        // check the previous entry before driving the next one
        for (int i = 0; i < numTests; i++) begin
            if (i > 0) finishTest(i - 1);
            memIn     = stim[i];
            mem2Wr    = wrs[i];
            mem2Flush = flushes[i];
            @(negedge clk);
        end
        finishTest(numTests - 1);
        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== design/memBackEnd.sv ====
`timescale 1ns/1ps

module memBackEnd (
    input  logic                            clk,
    input  logic                            rstN,
    input  cpuPkg::memBundleT               memIn,
    input  logic                            mem2Wr,
    input  logic                            mem2Flush,
    output logic [cpuPkg::dataWidth-1:0]    mem2Result,
    output logic [cpuPkg::regAddrWidth-1:0] mem2Dst,
    output cpuPkg::regsWrT                  mem2RegsWr,
    output cpuPkg::wbWriteT                 wbWrite,
    output cpuPkg::hiLoWriteT               hiLoWrite
);

    cpuPkg::mem2BundleT           mem2Out;
    logic [cpuPkg::dataWidth-1:0] rdata;

    // request comes straight from MEM, data lands with MEM2
    dataRam u_dataRam (
        .clk       (clk),
        .rstN      (rstN),
        .wr        (mem2Wr),
        .flush     (mem2Flush),
        .addr      (memIn.aluOut),
        .wdata     (memIn.outB),
        .storeType (memIn.storeType),
        .rdata     (rdata)
    );

    mem2Stage u_mem2Stage (
        .clk        (clk),
        .rstN       (rstN),
        .mem2Flush  (mem2Flush),
        .mem2Wr     (mem2Wr),
        .memIn      (memIn),
        .mem2Out    (mem2Out),
        .mem2Result (mem2Result),
        .mem2Dst    (mem2Dst),
        .mem2RegsWr (mem2RegsWr)
    );

    wbStage u_wbStage (
        .clk       (clk),
        .rstN      (rstN),
        .mem2Wr    (mem2Wr),
        .mem2In    (mem2Out),
        .rdata     (rdata),       // DMOut path
        .wbWrite   (wbWrite),
        .hiLoWrite (hiLoWrite)
    );

endmodule

// ==== design/wbStage.sv ====
`timescale 1ns/1ps

module wbStage (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         mem2Wr,
    input  cpuPkg::mem2BundleT           mem2In,
    input  logic [cpuPkg::dataWidth-1:0] rdata,
    output cpuPkg::wbWriteT              wbWrite,
    output cpuPkg::hiLoWriteT            hiLoWrite
);

    cpuPkg::mem2BundleT           wbQ;
    logic [cpuPkg::dataWidth-1:0] rdataQ;
    logic [cpuPkg::dataWidth-1:0] loadVal;
    logic [cpuPkg::dataWidth-1:0] wrData;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbQ    <= '0;
            rdataQ <= '0;
        end else begin
            wbQ    <= mem2In;
            rdataQ <= rdata;
            // MEM2 held this cycle, so no second write-back of it
            if (!mem2Wr) wbQ.regsWr <= '0;
        end
    end

    loadAlign u_loadAlign (
        .word       (rdataQ),
        .byteOffset (wbQ.aluOut[1:0]),   // address low bits
        .loadType   (wbQ.loadType),
        .value      (loadVal)
    );

    always_comb begin
        case (wbQ.wbSel)
            cpuPkg::wbPcPlus8: wrData = wbQ.pc + 32'd8;
            cpuPkg::wbAluOut:  wrData = wbQ.aluOut;
            cpuPkg::wbOutB:    wrData = wbQ.outB;
            default:           wrData = loadVal;   // wbDmOut
        endcase
    end

    // register file port
    assign wbWrite = '{
        rfWe: wbQ.regsWr.rfWr,
        dst:  wbQ.dst,
        data: wrData
    };

    // HI/LO always take operand B
    assign hiLoWrite = '{
        hiWe: wbQ.regsWr.hiWr,
        loWe: wbQ.regsWr.loWr,
        data: wbQ.outB
    };

endmodule

// ==== design/loadAlign.sv ====
`timescale 1ns/1ps

module loadAlign (
    input  logic [cpuPkg::dataWidth-1:0] word,
    input  logic [1:0]                   byteOffset,
    input  cpuPkg::loadTypeT             loadType,
    output logic [cpuPkg::dataWidth-1:0] value
);

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    // little-endian lane pick
    always_comb begin
        case (byteOffset)
            2'd0:    byteSel = word[7:0];
            2'd1:    byteSel = word[15:8];
            2'd2:    byteSel = word[23:16];
            default: byteSel = word[31:24];
        endcase
    end

    assign halfSel = byteOffset[1] ? word[31:16] : word[15:0];   // bit 0 ignored

    always_comb begin
        case (loadType)
            cpuPkg::ldByte: begin
                value = {{24{byteSel[7]}}, byteSel};     // lb
            end
            cpuPkg::ldByteU: begin
                value = {24'd0, byteSel};                // lbu
            end
            cpuPkg::ldHalf: begin
                value = {{16{halfSel[15]}}, halfSel};    // lh
            end
            cpuPkg::ldHalfU: begin
                value = {16'd0, halfSel};                // lhu
            end
            default: begin
                value = word;                            // lw
            end
        endcase
    end

endmodule

// ==== design/dataRam.sv ====
`timescale 1ns/1ps

module dataRam (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         wr,
    input  logic                         flush,
    input  logic [cpuPkg::dataWidth-1:0] addr,
    input  logic [cpuPkg::dataWidth-1:0] wdata,
    input  cpuPkg::storeTypeT            storeType,
    output logic [cpuPkg::dataWidth-1:0] rdata
);

    logic [cpuPkg::dataWidth-1:0]    mem [0:(1 << cpuPkg::ramDepthLog2)-1];
    logic [cpuPkg::ramDepthLog2-1:0] wordIdx;
    logic [3:0]                      byteEn;
    logic [cpuPkg::dataWidth-1:0]    laneData;
    logic                            storeEn;

    assign wordIdx = addr[cpuPkg::ramDepthLog2+1:2];   // word addressed
    assign storeEn = (storeType != cpuPkg::stNone) && wr && !flush;

    // lane enables from the low address bits, data copied to every lane
    always_comb begin
        case (storeType)
            cpuPkg::stWord: begin
                byteEn   = 4'b1111;
                laneData = wdata;
            end
            cpuPkg::stHalf: begin
                byteEn   = addr[1] ? 4'b1100 : 4'b0011;
                laneData = {2{wdata[15:0]}};
            end
            cpuPkg::stByte: begin
                byteEn   = 4'b0001 << addr[1:0];
                laneData = {4{wdata[7:0]}};
            end
            default: begin
                byteEn   = 4'b0000;
                laneData = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (storeEn) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) mem[wordIdx][8*i +: 8] <= laneData[8*i +: 8];
            end
        end
    end

    // read register only moves with MEM2, so it tracks the held instruction
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdata <= '0;
        end else if (wr) begin
            rdata <= mem[wordIdx];
        end
    end

endmodule

// ==== design/mem2Stage.sv ====
`timescale 1ns/1ps

module mem2Stage (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        mem2Flush,
    input  logic                        mem2Wr,
    input  cpuPkg::memBundleT           memIn,
    output cpuPkg::mem2BundleT          mem2Out,
    output logic [cpuPkg::dataWidth-1:0]    mem2Result,
    output logic [cpuPkg::regAddrWidth-1:0] mem2Dst,
    output cpuPkg::regsWrT              mem2RegsWr
);

    mem2Reg u_mem2Reg (
        .clk     (clk),
        .rstN    (rstN),
        .flush   (mem2Flush),
        .wr      (mem2Wr),
        .memIn   (memIn),
        .mem2Out (mem2Out)
    );

    // bypass value for the hazard unit
    always_comb begin
        case (mem2Out.wbSel)
            cpuPkg::wbPcPlus8: mem2Result = mem2Out.pc + 32'd8;   // jal, jalr
            cpuPkg::wbAluOut:  mem2Result = mem2Out.aluOut;
            cpuPkg::wbOutB:    mem2Result = mem2Out.outB;         // mthi, mtlo
            // load data is not ready for forwarding here,
            // outB only keeps the mux free of X
            default:           mem2Result = mem2Out.outB;
        endcase
    end

    // forwarding info
    assign mem2Dst    = mem2Out.dst;
    assign mem2RegsWr = mem2Out.regsWr;

endmodule

// ==== design/mem2Reg.sv ====
`timescale 1ns/1ps

module mem2Reg (
    input  logic               clk,
    input  logic               rstN,
    input  logic               flush,
    input  logic               wr,
    input  cpuPkg::memBundleT  memIn,
    output cpuPkg::mem2BundleT mem2Out
);

    cpuPkg::mem2BundleT nextVal;

    // storeType stops here, the RAM has already seen it
    always_comb begin
        nextVal = '{
            pc:       memIn.pc,
            aluOut:   memIn.aluOut,
            outB:     memIn.outB,
            dst:      memIn.dst,
            wbSel:    memIn.wbSel,
            regsWr:   memIn.regsWr,
            loadType: memIn.loadType
        };
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mem2Out <= '0;              // bubble
        end else if (wr) begin
            if (flush) begin
                mem2Out <= '0;          // squashed entry
            end else begin
                mem2Out <= nextVal;
            end
        end
        // wr low: hold for the stall
    end

endmodule

// ==== design/cpuPkg.sv ====
package cpuPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int ramDepthLog2 = 8;   // 256 words

    // write-back source, also drives the MEM2 bypass mux
    typedef enum logic [1:0] {
        wbPcPlus8,
        wbAluOut,
        wbOutB,
        wbDmOut
    } wbSelT;

    typedef enum logic [2:0] {
        ldWord,
        ldByte,
        ldByteU,
        ldHalf,
        ldHalfU
    } loadTypeT;

    typedef enum logic [1:0] {
        stNone,
        stWord,
        stByte,
        stHalf
    } storeTypeT;

    typedef struct packed {
        logic rfWr;
        logic hiWr;
        logic loWr;
    } regsWrT;

    // MEM -> MEM2
    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        logic [dataWidth-1:0]    aluOut;   // also the data address
        logic [dataWidth-1:0]    outB;     // store data, HI/LO data
        logic [regAddrWidth-1:0] dst;
        wbSelT                   wbSel;
        regsWrT                  regsWr;
        loadTypeT                loadType;
        storeTypeT               storeType;
    } memBundleT;

    // MEM2 -> WB, store already done
    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        logic [dataWidth-1:0]    aluOut;
        logic [dataWidth-1:0]    outB;
        logic [regAddrWidth-1:0] dst;
        wbSelT                   wbSel;
        regsWrT                  regsWr;
        loadTypeT                loadType;
    } mem2BundleT;

    typedef struct packed {
        logic                    rfWe;
        logic [regAddrWidth-1:0] dst;
        logic [dataWidth-1:0]    data;
    } wbWriteT;

    typedef struct packed {
        logic                 hiWe;
        logic                 loWe;
        logic [dataWidth-1:0] data;
    } hiLoWriteT;

endpackage
